//--- verif/frame_trace.txt
# W addr(dec) data(hex) | F frames to run | P pause percent
# E leader_beats image_width trailer_beats image_lines checksum(hex), one per frame in order
F 1
E 7 32 6 12 1f80
W 3 14
W 5 8
F 2
E 7 32 6 12 2100
E 7 20 6 8 960
W 6 1
W 7 1234
F 2
E 7 20 6 8 a00
E 7 20 6 8 b6080
W 6 2
F 2
E 7 20 6 8 b6080
E 7 20 6 8 4fffb0
P 25
W 6 0
W 3 20
W 5 c
F 3
E 7 20 6 8 4fffb0
E 7 32 6 12 2b80
E 7 32 6 12 2d00
P 0
F 1
E 7 32 6 12 2e80

//--- project.f
+incdir+design
design/video_pkg.sv
design/timing_regs.sv
design/frame_timing.sv
design/pattern_gen.sv
design/frame_source_top.sv
verif/frame_checker.sv
verif/tb_frame_source.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_frame_source
FILELIST = project.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = Verification passed

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/tb_frame_source.sv
// testbench top for the frame source
// clock, reset, trace reader and command player
// register writes, LCG driven pause, timeout and closing report
`timescale 1ns/1ps
`include "video_defines.svh"

module tb_frame_source;

	// one trace command, op is the command letter
	typedef struct packed {
		logic [7:0]  op;
		logic [15:0] a;
		logic [15:0] b;
	} cmd_t;

	logic                    clk       = 1'b0;
	logic                    reset_n   = 1'b0;
	logic                    cfg_we    = 1'b0;
	video_pkg::reg_addr_e    cfg_addr  = video_pkg::ADDR_H_PERIOD;
	logic [`VID_CNT_W-1:0]   cfg_wdata = '0;
	logic                    pause     = 1'b0;
	video_pkg::video_beat_t  beat;

	cmd_t        cmds[$];
	int          pause_density = 0;
	int          tb_errors     = 0;
	int          cycle_count   = 0;
	int          cycle_limit   = 0;
	logic [31:0] rnd           = 32'h7b61cf14;

	always #2 clk = ~clk;

	frame_source_top frame_source_top_i
	(
		.clk         (clk),
		.reset_n     (reset_n),
		.i_cfg_we    (cfg_we),
		.i_cfg_addr  (cfg_addr),
		.i_cfg_wdata (cfg_wdata),
		.i_pause     (pause),
		.o_beat      (beat)
	);

	frame_checker frame_checker_i
	(
		.clk     (clk),
		.reset_n (reset_n),
		.i_beat  (beat)
	);

	// ============================================================
	// helpers
	// ============================================================
	function automatic logic [31:0] next_random(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic write_reg(input logic [2:0] addr, input logic [15:0] data);
		@(posedge clk);
		cfg_we    <= 1'b1;
		cfg_addr  <= video_pkg::reg_addr_e'(addr);
		cfg_wdata <= data;
		@(posedge clk);
		cfg_we    <= 1'b0;
	endtask

	// counts vend on the output, one per frame
	task automatic run_frames(input int n);
		int seen;
		seen = 0;
		while (seen < n)
		begin
			@(posedge clk);
			if (beat.vend)
				seen++;
		end
	endtask

	task finish_run();
		$display("errors: checker %0d, testbench %0d", frame_checker_i.err_count, tb_errors);
		if ((frame_checker_i.err_count + tb_errors) == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	endtask

	// pause level, density in percent
	always @(posedge clk)
	begin
		rnd   <= next_random(rnd);
		pause <= (pause_density > 0) && ((int'(rnd[31:16]) % 100) < pause_density);
	end

	// ============================================================
	// timeout
	// ============================================================
	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if ((cycle_limit > 0) && (cycle_count > cycle_limit))
		begin
			$display("run timed out after %0d cycles before the trace was done", cycle_count);
			tb_errors = tb_errors + 1;
			finish_run();
		end
	end

	// ============================================================
	// trace parse, then play
	// ============================================================
	initial
	begin
		int          fd;
		string       line;
		byte         op;
		int          a;
		int          b;
		int          lead;
		int          img;
		int          trl;
		int          lines;
		logic [31:0] sum;
		int          h_cur;
		int          v_cur;
		int          dens;
		int          fc;
		int          limit;
		cmd_t        cmd;
		h_cur = `VID_DEF_H_PERIOD;
		v_cur = `VID_DEF_V_PERIOD;
		dens  = 0;
		limit = 0;
		fd = $fopen("verif/frame_trace.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open verif/frame_trace.txt, nothing to run");
			tb_errors++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				void'($fgets(line, fd));
				if ((line.len() < 2) || (line[0] == "#"))
					continue;
				op = line[0];
				a  = 0;
				b  = 0;
				case (op)
					"W": void'($sscanf(line, "W %d %h", a, b));
					"F": void'($sscanf(line, "F %d", a));
					"P": void'($sscanf(line, "P %d", a));
					"E":
					begin
						void'($sscanf(line, "E %d %d %d %d %h", lead, img, trl, lines, sum));
						frame_checker_i.add_expectation(lead, img, trl, lines, sum);
					end
					default: $display("unknown trace command: %s", line);
				endcase
				// periods tracked only for the run limit
				if ((op == "W") && (a == 0))
					h_cur = b;
				if ((op == "W") && (a == 1))
					v_cur = b;
				if (op == "P")
					dens = a;
				fc = (h_cur + 1) * (v_cur + 1);
				if (op == "F")
					limit = limit + 2 * fc * a + ((dens > 0) ? 4 * fc * a : 0);
				if (op != "E")
				begin
					cmd = '{op: op, a: a[15:0], b: b[15:0]};
					cmds.push_back(cmd);
				end
			end
			$fclose(fd);
		end
		// reset and a little slack on top
		cycle_limit = limit + 80;
		repeat (16) @(posedge clk);
		reset_n <= 1'b1;
		foreach (cmds[i])
		begin
			case (cmds[i].op)
				"W": write_reg(cmds[i].a[2:0], cmds[i].b);
				"F": run_frames(cmds[i].a);
				"P": pause_density = cmds[i].a;
				default: ;
			endcase
		end
		if (frame_checker_i.pending_count() != 0)
		begin
			$display("%0d expected frames from the trace were never seen",
			         frame_checker_i.pending_count());
			tb_errors++;
		end
		finish_run();
	end

endmodule

//--- verif/frame_checker.sv
// output monitor for the frame source
// rebuilds leader, image and trailer lines of each frame
// checks words, beat counts, trailer flag and pulse counts
// compares per-frame results with trace expectations
`timescale 1ns/1ps
`include "video_defines.svh"

module frame_checker
(
	input logic                   clk,
	input logic                   reset_n,
	input video_pkg::video_beat_t i_beat
);

	// one E line of the trace
	typedef struct packed {
		logic [15:0] leader_beats;
		logic [15:0] image_beats;
		logic [15:0] trailer_beats;
		logic [15:0] image_lines;
		logic [31:0] checksum;
	} expect_t;

	expect_t                exp_q[$];
	expect_t                cur_exp;
	int                     err_count = 0;
	int                     frame_id;
	int                     image_lines;
	int                     hend_count;
	int                     line_no;
	logic                   seen_vend;
	logic                   in_frame;
	logic                   prev_fval;
	logic                   prev_flag;
	logic [31:0]            frame_sum;
	// open line
	logic [`VID_DATA_W-1:0] line_words[$];
	logic                   line_flags[$];
	logic                   line_pre_flag;
	// last closed line, image until it turns out to be the trailer
	logic [`VID_DATA_W-1:0] held_words[$];
	logic                   held_flags[$];
	logic                   held_pre_flag;
	logic                   held_valid;

	task automatic add_expectation(input int lead, input int img, input int trl,
	                               input int lines, input logic [31:0] sum);
		expect_t e;
		e = '{leader_beats: lead[15:0], image_beats: img[15:0], trailer_beats: trl[15:0],
		      image_lines: lines[15:0], checksum: sum};
		exp_q.push_back(e);
	endtask

	function automatic int pending_count();
		return exp_q.size();
	endfunction

	task automatic compare_value(input string name, input logic [31:0] exp,
	                             input logic [31:0] act);
		if (exp !== act)
		begin
			err_count++;
			$display("** Error %s: expected 0x%0h, actual 0x%0h", name, exp, act);
		end
	endtask

	// ============================================================
	// line checks
	// ============================================================
	task automatic check_leader();
		logic [31:0] word;
		compare_value($sformatf("frame %0d leader beats", frame_id),
		              `VID_LEADER_BEATS, line_words.size());
		compare_value($sformatf("frame %0d leader beats vs trace", frame_id),
		              cur_exp.leader_beats, line_words.size());
		foreach (line_words[i])
		begin
			word = (i == 0) ? `VID_LEADER_MAGIC : ((i == 1) ? frame_id[15:0] : 32'd0);
			compare_value($sformatf("frame %0d leader word %0d", frame_id, i),
			              word, line_words[i]);
			compare_value($sformatf("frame %0d leader flag %0d", frame_id, i), 0, line_flags[i]);
		end
	endtask

	// held line turned out to be an image line
	task automatic take_image();
		compare_value($sformatf("frame %0d row %0d beats", frame_id, image_lines),
		              cur_exp.image_beats, held_words.size());
		foreach (held_words[i])
		begin
			frame_sum = frame_sum + held_words[i];
			if (held_flags[i])
				compare_value($sformatf("frame %0d row %0d flag", frame_id, image_lines), 0, 1);
		end
		image_lines++;
	endtask

	task automatic check_trailer();
		logic [31:0] word;
		compare_value($sformatf("frame %0d trailer beats", frame_id),
		              `VID_TRAILER_BEATS, held_words.size());
		compare_value($sformatf("frame %0d trailer beats vs trace", frame_id),
		              cur_exp.trailer_beats, held_words.size());
		// flag opens a cycle early, drops on the last beat
		compare_value($sformatf("frame %0d trailer flag lead", frame_id), 1, held_pre_flag);
		foreach (held_words[i])
		begin
			word = (i == 0) ? `VID_TRAILER_MAGIC : 32'd0;
			if (i == 1)
				word = frame_id[15:0];
			else if (i == 2)
				word = cur_exp.image_lines;
			compare_value($sformatf("frame %0d trailer word %0d", frame_id, i),
			              word, held_words[i]);
			compare_value($sformatf("frame %0d trailer flag %0d", frame_id, i),
			              (i < `VID_TRAILER_BEATS - 1), held_flags[i]);
		end
	endtask

	task automatic close_line();
		if (line_no == 0)
			check_leader();
		else
		begin
			if (held_valid)
				take_image();
			held_words    = line_words;
			held_flags    = line_flags;
			held_pre_flag = line_pre_flag;
			held_valid    = 1'b1;
		end
		line_no++;
	endtask

	// ============================================================
	// frame boundaries
	// ============================================================
	task automatic start_frame();
		if (exp_q.size() == 0)
		begin
			err_count++;
			$display("frame %0d arrived with no expected entry left in the trace", frame_id);
			cur_exp = '0;
		end
		else
			cur_exp = exp_q.pop_front();
		in_frame    = 1'b1;
		line_no     = 0;
		held_valid  = 1'b0;
		image_lines = 0;
		frame_sum   = '0;
	endtask

	task automatic end_frame();
		if (held_valid)
			check_trailer();
		else
		begin
			err_count++;
			$display("frame %0d ended without a trailer line", frame_id);
		end
		compare_value($sformatf("frame %0d image lines", frame_id),
		              cur_exp.image_lines, image_lines);
		compare_value($sformatf("frame %0d checksum", frame_id), cur_exp.checksum, frame_sum);
		in_frame = 1'b0;
		frame_id++;
	endtask

	always @(posedge clk)
	begin
		if (!reset_n)
		begin
			in_frame   = 1'b0;
			prev_fval  = 1'b0;
			prev_flag  = 1'b0;
			seen_vend  = 1'b0;
			hend_count = 0;
			frame_id   = 0;
			line_words.delete();
			line_flags.delete();
		end
		else
		begin
			if (i_beat.dval)
			begin
				if (!i_beat.fval)
					compare_value($sformatf("frame %0d fval on data beat", frame_id), 1, 0);
				if (line_words.size() == 0)
					line_pre_flag = prev_flag;
				line_words.push_back(i_beat.data);
				line_flags.push_back(i_beat.trailer_flag);
			end
			if (i_beat.hend)
			begin
				hend_count++;
				if (in_frame && (line_words.size() > 0))
					close_line();
				line_words.delete();
				line_flags.delete();
			end
			// hend of the last line shares the cycle with vend
			if (i_beat.vend)
			begin
				if (seen_vend)
					compare_value($sformatf("frame %0d hend pulses", frame_id),
					              `VID_DEF_V_PERIOD + 1, hend_count);
				seen_vend  = 1'b1;
				hend_count = 0;
			end
			if (i_beat.fval && !prev_fval)
				start_frame();
			else if (!i_beat.fval && prev_fval)
				end_frame();
			prev_fval = i_beat.fval;
			prev_flag = i_beat.trailer_flag;
		end
	end

endmodule

//--- design/frame_source_top.sv
// frame source top level
// register block, timing generator and pattern generator
// vend fed back as the frame boundary for config updates
`timescale 1ns/1ps
`include "video_defines.svh"

module frame_source_top
(
	input  logic                   clk,
	input  logic                   reset_n,
	input  logic                   i_cfg_we,
	input  video_pkg::reg_addr_e   i_cfg_addr,
	input  logic [`VID_CNT_W-1:0]  i_cfg_wdata,
	input  logic                   i_pause,
	output video_pkg::video_beat_t o_beat
);

	video_pkg::cfg_t    cfg;
	video_pkg::timing_t timing;

	// config, active copy swaps after each vend
	timing_regs timing_regs_i
	(
		.clk         (clk),
		.reset_n     (reset_n),
		.i_cfg_we    (i_cfg_we),
		.i_cfg_addr  (i_cfg_addr),
		.i_cfg_wdata (i_cfg_wdata),
		.i_frame_end (timing.vend),
		.o_cfg       (cfg)
	);

	// counters and flags
	frame_timing frame_timing_i
	(
		.clk      (clk),
		.reset_n  (reset_n),
		.i_cfg    (cfg),
		.i_pause  (i_pause),
		.o_timing (timing)
	);

	// payload, one more cycle
	pattern_gen pattern_gen_i
	(
		.clk      (clk),
		.reset_n  (reset_n),
		.i_timing (timing),
		.i_cfg    (cfg),
		.o_beat   (o_beat)
	);

endmodule

//--- design/pattern_gen.sv
// payload generator for leader, image and trailer beats
// beat, row and frame counters
// ramp, fill and checkerboard image patterns
// one cycle realignment of the timing flags
`timescale 1ns/1ps
`include "video_defines.svh"

module pattern_gen
(
	input  logic                   clk,
	input  logic                   reset_n,
	input  video_pkg::timing_t     i_timing,
	input  video_pkg::cfg_t        i_cfg,
	output video_pkg::video_beat_t o_beat
);

	logic [`VID_CNT_W-1:0]   beat_idx;
	logic [`VID_CNT_W-1:0]   row_idx;
	logic [`VID_DATA_W-1:0]  frame_id;
	logic                    fval_fall;
	logic [`VID_DATA_W-1:0]  pixel;
	logic [`VID_DATA_W-1:0]  word_d;
	video_pkg::video_beat_t  beat_q;

	// previous fval taken from the output register
	assign fval_fall = beat_q.fval && !i_timing.fval;

	// ============================================================
	// position counters
	// ============================================================
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			beat_idx <= '0;
			row_idx  <= '0;
			frame_id <= '0;
		end
		else
		begin
			// hend and dval never share a cycle
			if (i_timing.hend)
				beat_idx <= '0;
			else if (i_timing.dval)
				beat_idx <= beat_idx + 1'b1;
			// kind still names the ending line at hend
			if (fval_fall)
			begin
				row_idx  <= '0;
				frame_id <= frame_id + 1'b1;
			end
			else if (i_timing.hend && (i_timing.kind == video_pkg::LINE_IMAGE))
				row_idx <= row_idx + 1'b1;
		end
	end

	// ============================================================
	// image pixel
	// ============================================================
	always_comb
	begin
		case (i_cfg.pattern_sel)
			// ramp, wraps at the data width
			2'd0:    pixel = beat_idx[`VID_DATA_W-1:0] + row_idx[`VID_DATA_W-1:0] + frame_id;
			2'd1:    pixel = i_cfg.fill_value;
			// checkerboard on single pixels
			2'd2:    pixel = (beat_idx[0] ^ row_idx[0]) ? '1 : '0;
			default: pixel = '0;
		endcase
	end

	// ============================================================
	// word select by line kind
	// ============================================================
	always_comb
	begin
		word_d = '0;
		if (i_timing.dval)
		begin
			case (i_timing.kind)
				video_pkg::LINE_LEADER:
				begin
					if (beat_idx == 0)
						word_d = `VID_LEADER_MAGIC;
					else if (beat_idx == 1)
						word_d = frame_id;
				end
				video_pkg::LINE_IMAGE:
					word_d = pixel;
				video_pkg::LINE_TRAILER:
				begin
					if (beat_idx == 0)
						word_d = `VID_TRAILER_MAGIC;
					else if (beat_idx == 1)
						word_d = frame_id;
					else if (beat_idx == 2)
						word_d = i_cfg.height[`VID_DATA_W-1:0];
				end
				default:
					word_d = '0;
			endcase
		end
	end

	// flags and data leave together, one clock later
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			beat_q <= '0;
		else
			beat_q <= '{fval: i_timing.fval, dval: i_timing.dval,
			            trailer_flag: i_timing.trailer_flag, hend: i_timing.hend,
			            vend: i_timing.vend, data: word_d};
	end

	assign o_beat = beat_q;

endmodule

//--- design/frame_timing.sv
// frame timing generator, U3V form
// horizontal and vertical counters with end pulses
// fval, dval with short leader and trailer lines, trailer flag
// line classification for the payload stage
`timescale 1ns/1ps
`include "video_defines.svh"

module frame_timing
(
	input  logic                 clk,
	input  logic                 reset_n,
	input  video_pkg::cfg_t      i_cfg,
	input  logic                 i_pause,
	output video_pkg::timing_t   o_timing
);

	localparam logic [`VID_CNT_W-1:0] LEADER_LEN  = `VID_LEADER_BEATS;
	localparam logic [`VID_CNT_W-1:0] TRAILER_LEN = `VID_TRAILER_BEATS;

	logic [`VID_CNT_W-1:0]  hcount;
	logic [`VID_CNT_W-1:0]  vcount;
	logic                   wrap;
	// line numbers of leader and trailer
	logic [`VID_CNT_W-1:0]  fval_start_m1;
	logic [`VID_CNT_W-1:0]  last_line;
	// valid length of the current line and its end
	logic [`VID_CNT_W-1:0]  dval_len;
	logic [`VID_CNT_W-1:0]  dval_stop;
	video_pkg::line_kind_e  cur_kind;

	logic                   fval;
	logic                   dval;
	logic                   trailer_flag;
	logic                   hend;
	logic                   vend;
	video_pkg::line_kind_e  kind;

	assign wrap          = (hcount == i_cfg.h_period);
	assign fval_start_m1 = i_cfg.fval_start - 1'b1;
	assign last_line     = i_cfg.fval_start + i_cfg.height + 1'b1;
	assign dval_stop     = i_cfg.dval_start + dval_len;

	// ============================================================
	// line classification
	// ============================================================
	always_comb
	begin
		cur_kind = video_pkg::LINE_BLANK;
		dval_len = '0;
		if (vcount == i_cfg.fval_start)
		begin
			cur_kind = video_pkg::LINE_LEADER;
			dval_len = LEADER_LEN;
		end
		else if (vcount == last_line)
		begin
			cur_kind = video_pkg::LINE_TRAILER;
			dval_len = TRAILER_LEN;
		end
		else if ((vcount > i_cfg.fval_start) && (vcount < last_line))
		begin
			cur_kind = video_pkg::LINE_IMAGE;
			dval_len = i_cfg.width;
		end
	end

	// ============================================================
	// counters and end pulses
	// ============================================================
	// hcount wraps even while paused, otherwise pause freezes it
	// vcount follows every wrap so a paused wrap never replays a line
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			hcount <= '0;
			vcount <= '0;
			hend   <= 1'b0;
			vend   <= 1'b0;
		end
		else
		begin
			hend <= wrap;
			vend <= wrap && (vcount == i_cfg.v_period);
			if (wrap)
			begin
				hcount <= '0;
				if (vcount == i_cfg.v_period)
					vcount <= '0;
				else
					vcount <= vcount + 1'b1;
			end
			else if (!i_pause)
				hcount <= hcount + 1'b1;
		end
	end

	// ============================================================
	// fval, dval, trailer flag, kind
	// ============================================================
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			fval         <= 1'b0;
			dval         <= 1'b0;
			trailer_flag <= 1'b0;
			kind         <= video_pkg::LINE_BLANK;
		end
		else
		begin
			// fval toggles only at line boundaries
			if (wrap && (vcount == fval_start_m1))
				fval <= 1'b1;
			else if (wrap && (vcount == last_line))
				fval <= 1'b0;
			// one beat per unpaused hcount value inside the window
			dval <= !i_pause && (cur_kind != video_pkg::LINE_BLANK) &&
			        (hcount >= i_cfg.dval_start) && (hcount < dval_stop);
			// flag opens one clock ahead of the first trailer beat
			trailer_flag <= (cur_kind == video_pkg::LINE_TRAILER) &&
			                (hcount >= i_cfg.dval_start - 1'b1) &&
			                (hcount <= i_cfg.dval_start + 3'd4);
			kind <= cur_kind;
		end
	end

	assign o_timing = '{fval: fval, dval: dval, trailer_flag: trailer_flag,
	                    hend: hend, vend: vend, kind: kind};

endmodule

//--- design/timing_regs.sv
// timing register block
// write port into a staged register set
// active config copied from staged set at frame end and after reset
`timescale 1ns/1ps
`include "video_defines.svh"

module timing_regs
(
	input  logic                      clk,
	input  logic                      reset_n,
	input  logic                      i_cfg_we,
	input  video_pkg::reg_addr_e      i_cfg_addr,
	input  logic [`VID_CNT_W-1:0]     i_cfg_wdata,
	input  logic                      i_frame_end,
	output video_pkg::cfg_t           o_cfg
);

	video_pkg::cfg_t staged;
	video_pkg::cfg_t active;
	// one extra load right after reset release
	logic            init_load;

	// ============================================================
	// staged set, written any time
	// ============================================================
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			staged.h_period    <= `VID_DEF_H_PERIOD;
			staged.v_period    <= `VID_DEF_V_PERIOD;
			staged.dval_start  <= `VID_DEF_DVAL_START;
			staged.width       <= `VID_DEF_WIDTH;
			staged.fval_start  <= `VID_DEF_FVAL_START;
			staged.height      <= `VID_DEF_HEIGHT;
			staged.pattern_sel <= `VID_DEF_PATTERN;
			staged.fill_value  <= `VID_DEF_FILL;
		end
		else if (i_cfg_we)
		begin
			case (i_cfg_addr)
				video_pkg::ADDR_H_PERIOD:   staged.h_period    <= i_cfg_wdata;
				video_pkg::ADDR_V_PERIOD:   staged.v_period    <= i_cfg_wdata;
				video_pkg::ADDR_DVAL_START: staged.dval_start  <= i_cfg_wdata;
				video_pkg::ADDR_WIDTH:      staged.width       <= i_cfg_wdata;
				video_pkg::ADDR_FVAL_START: staged.fval_start  <= i_cfg_wdata;
				video_pkg::ADDR_HEIGHT:     staged.height      <= i_cfg_wdata;
				// only the low bits select a pattern
				video_pkg::ADDR_PATTERN:    staged.pattern_sel <= i_cfg_wdata[1:0];
				video_pkg::ADDR_FILL:       staged.fill_value  <= i_cfg_wdata[`VID_DATA_W-1:0];
			endcase
		end
	end

	// ============================================================
	// active copy, changes only between frames
	// ============================================================
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			init_load <= 1'b1;
			active    <= '{h_period:    `VID_DEF_H_PERIOD,
			               v_period:    `VID_DEF_V_PERIOD,
			               dval_start:  `VID_DEF_DVAL_START,
			               width:       `VID_DEF_WIDTH,
			               fval_start:  `VID_DEF_FVAL_START,
			               height:      `VID_DEF_HEIGHT,
			               pattern_sel: `VID_DEF_PATTERN,
			               fill_value:  `VID_DEF_FILL};
		end
		else
		begin
			init_load <= 1'b0;
			// vend arrives registered, so this lands one cycle after it
			if (init_load || i_frame_end)
				active <= staged;
		end
	end

	assign o_cfg = active;

endmodule

//--- design/video_pkg.sv
// shared types of the frame source
// config struct, timing flags, line kinds
// output beat and register address map
`include "video_defines.svh"

package video_pkg;

	// ============================================================
	// register map
	// ============================================================
	typedef enum logic [2:0] {
		ADDR_H_PERIOD   = 3'd0,
		ADDR_V_PERIOD   = 3'd1,
		ADDR_DVAL_START = 3'd2,
		ADDR_WIDTH      = 3'd3,
		ADDR_FVAL_START = 3'd4,
		ADDR_HEIGHT     = 3'd5,
		ADDR_PATTERN    = 3'd6,
		ADDR_FILL       = 3'd7
	} reg_addr_e;

	// timing parameters plus pattern selection
	typedef struct packed {
		logic [`VID_CNT_W-1:0]  h_period;
		logic [`VID_CNT_W-1:0]  v_period;
		logic [`VID_CNT_W-1:0]  dval_start;
		logic [`VID_CNT_W-1:0]  width;
		logic [`VID_CNT_W-1:0]  fval_start;
		logic [`VID_CNT_W-1:0]  height;
		logic [1:0]             pattern_sel;
		logic [`VID_DATA_W-1:0] fill_value;
	} cfg_t;

	// what the current line carries
	typedef enum logic [1:0] {
		LINE_BLANK   = 2'd0,
		LINE_LEADER  = 2'd1,
		LINE_IMAGE   = 2'd2,
		LINE_TRAILER = 2'd3
	} line_kind_e;

	// counter stage to payload stage
	typedef struct packed {
		logic       fval;
		logic       dval;
		logic       trailer_flag;
		logic       hend;
		logic       vend;
		line_kind_e kind;
	} timing_t;

	// one output beat
	typedef struct packed {
		logic                   fval;
		logic                   dval;
		logic                   trailer_flag;
		logic                   hend;
		logic                   vend;
		logic [`VID_DATA_W-1:0] data;
	} video_beat_t;

endpackage

//--- design/video_defines.svh
// frame source widths and counter sizes
// reset values of the timing registers
// leader and trailer magic words and beat counts
`ifndef VIDEO_DEFINES_SVH
`define VIDEO_DEFINES_SVH

// ============================================================
// widths
// ============================================================
`define VID_DATA_W          16
`define VID_CNT_W           16

// ============================================================
// timing defaults after reset
// ============================================================
// 48 clocks per line, 20 lines per frame
`define VID_DEF_H_PERIOD    16'd47
`define VID_DEF_V_PERIOD    16'd19
`define VID_DEF_DVAL_START  16'd8
`define VID_DEF_WIDTH       16'd32
// leader on line 2, image 3..14, trailer on 15
`define VID_DEF_FVAL_START  16'd2
`define VID_DEF_HEIGHT      16'd12
`define VID_DEF_PATTERN     2'd0
`define VID_DEF_FILL        16'h0a5a

// ============================================================
// U3V leader and trailer
// ============================================================
`define VID_LEADER_MAGIC    16'h4c56
`define VID_TRAILER_MAGIC   16'h5456
`define VID_LEADER_BEATS    7
`define VID_TRAILER_BEATS   6

`endif
